// File: include/mul_defs.svh
////////////////////////////////////////////////////////////
// vector multiply unit constants
// vector and scalar sizes, rob tag width, queue depth
////////////////////////////////////////////////////////////

`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

`define MUL_VLEN      128  // vector register width
`define MUL_VLENB     16   // bytes per vector
`define MUL_XLEN      32   // scalar operand width
`define MUL_TAG_W     4    // rob tag width

// result queue entries, also the station's credits after reset
`define MUL_BUF_DEPTH 4
`define MUL_CREDIT_W  3    // credit counter width

`endif

// File: hw/mul_pkg.sv
////////////////////////////////////////////////////////////
// vector multiply unit types
// operation, width and rounding encodings plus the
// structs passed between pipeline stages
////////////////////////////////////////////////////////////

`default_nettype none

`include "mul_defs.svh"

package mul_pkg;

  // codes 5..7 decode as MUL
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHU  = 3'd2,
    MULHSU = 3'd3,
    SMUL   = 3'd4
  } mul_op_e;

  // code 3 decodes as EEW8
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } mul_eew_e;

  // fixed-point rounding modes, RISC-V vxrm encoding
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } mul_vxrm_e;

  typedef struct packed {
    logic [`MUL_TAG_W-1:0] tag;
    mul_op_e               op;
    logic                  is_vx;  // src1 from rs1
    mul_eew_e              eew;
    mul_vxrm_e             vxrm;
    logic [`MUL_VLEN-1:0]  vs2;
    logic [`MUL_VLEN-1:0]  vs1;
    logic [`MUL_XLEN-1:0]  rs1;
  } mul_uop_t;

  typedef struct packed {
    logic [`MUL_TAG_W-1:0] tag;
    mul_eew_e              eew;
    mul_vxrm_e             vxrm;
    logic                  src2_signed;
    logic                  src1_signed;
    logic                  keep_low;  // low half of product
    logic                  is_smul;
  } mul_ctrl_t;

  typedef struct packed {
    mul_ctrl_t         ctrl;
    logic [63:0][15:0] pp;  // index z*16 + y*4 + x
  } mul_stage_t;

  typedef struct packed {
    logic [`MUL_TAG_W-1:0] tag;
    logic [`MUL_VLEN-1:0]  data;
    logic [`MUL_VLENB-1:0] vxsat;
  } mul_result_t;

endpackage

`default_nettype wire

// File: hw/mul_uop_decode.sv
////////////////////////////////////////////////////////////
// micro-op decoder
// builds byte operands, per-byte sign flags and the
// pipeline controls from one multiply micro-op
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_uop_decode (
  input  mul_pkg::mul_uop_t      uop,
  input  logic                   uop_valid,
  output logic [`MUL_VLEN-1:0]   src2,
  output logic [`MUL_VLEN-1:0]   src1,
  output logic [`MUL_VLENB-1:0]  src2_signed_b,
  output logic [`MUL_VLENB-1:0]  src1_signed_b,
  output mul_pkg::mul_ctrl_t     ctrl
);

  logic                   s2_signed;
  logic                   s1_signed;
  logic                   keep_low;
  logic                   is_smul;
  mul_pkg::mul_eew_e      eew;
  logic [`MUL_VLENB-1:0]  top_mask;  // top byte of each element
  logic [`MUL_VLEN-1:0]   scalar;

  // operation to signedness and result select
  always_comb begin
    s2_signed = 1'b1;
    s1_signed = 1'b1;
    keep_low  = 1'b1;
    is_smul   = 1'b0;
    case (uop.op)
      mul_pkg::MULH: keep_low = 1'b0;
      mul_pkg::MULHU: begin
        s2_signed = 1'b0;
        s1_signed = 1'b0;
        keep_low  = 1'b0;
      end
      mul_pkg::MULHSU: begin
        s1_signed = 1'b0;  // vs2 signed, vs1 unsigned
        keep_low  = 1'b0;
      end
      mul_pkg::SMUL: begin
        keep_low = 1'b0;
        is_smul  = 1'b1;
      end
      default: ;  // vmul
    endcase
  end

  // element width, sign byte positions, scalar splat
  always_comb begin
    eew      = mul_pkg::EEW8;
    top_mask = 16'hffff;
    scalar   = {16{uop.rs1[7:0]}};
    case (uop.eew)
      mul_pkg::EEW16: begin
        eew      = mul_pkg::EEW16;
        top_mask = 16'haaaa;
        scalar   = {8{uop.rs1[15:0]}};
      end
      mul_pkg::EEW32: begin
        eew      = mul_pkg::EEW32;
        top_mask = 16'h8888;
        scalar   = {4{uop.rs1[31:0]}};
      end
      default: ;
    endcase
  end

  always_comb begin
    src2          = '0;  // idle array sees zeros
    src1          = '0;
    src2_signed_b = '0;
    src1_signed_b = '0;
    ctrl          = '0;
    if (uop_valid) begin
      src2             = uop.vs2;
      src1             = uop.is_vx ? scalar : uop.vs1;
      src2_signed_b    = top_mask & {`MUL_VLENB{s2_signed}};
      src1_signed_b    = top_mask & {`MUL_VLENB{s1_signed}};
      ctrl.tag         = uop.tag;
      ctrl.eew         = eew;
      ctrl.vxrm        = uop.vxrm;
      ctrl.src2_signed = s2_signed;
      ctrl.src1_signed = s1_signed;
      ctrl.keep_low    = keep_low;
      ctrl.is_smul     = is_smul;
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_byte_array.sv
////////////////////////////////////////////////////////////
// byte multiplier array
// 64 signed/unsigned 8x8 multipliers in four 4x4 tiles,
// followed by the stage-one pipeline register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_byte_array (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [`MUL_VLEN-1:0]   src2,
  input  logic [`MUL_VLEN-1:0]   src1,
  input  logic [`MUL_VLENB-1:0]  src2_signed_b,
  input  logic [`MUL_VLENB-1:0]  src1_signed_b,
  input  mul_pkg::mul_ctrl_t     ctrl,
  output logic                   stage_valid,
  output mul_pkg::mul_stage_t    stage
);

  logic [63:0][15:0] pp;

  // each 32-bit group multiplies its 4 src2 bytes (x)
  // against its 4 src1 bytes (y)
  always_comb begin : tile_mul
    int               z;
    int               x;
    int               y;
    int               a_idx;
    int               b_idx;
    logic signed [8:0]  a9;
    logic signed [8:0]  b9;
    logic signed [17:0] p18;
    for (z = 0; z < 4; z++) begin
      for (y = 0; y < 4; y++) begin
        for (x = 0; x < 4; x++) begin
          a_idx = z*4 + x;
          b_idx = z*4 + y;
          a9  = {src2_signed_b[a_idx] & src2[a_idx*8+7], src2[a_idx*8 +: 8]};
          b9  = {src1_signed_b[b_idx] & src1[b_idx*8+7], src1[b_idx*8 +: 8]};
          p18 = a9 * b9;
          pp[z*16 + y*4 + x] = p18[15:0];  // product always fits 16 bits
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage one register, no stall
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    stage.ctrl <= ctrl;
    stage.pp   <= pp;
  end

endmodule

`default_nettype wire

// File: hw/mul_lane_combine.sv
////////////////////////////////////////////////////////////
// lane combiner
// sums partial products into 8/16/32-bit element products,
// then selects high/low half or rounds and saturates vsmul
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_lane_combine (
  input  mul_pkg::mul_stage_t   stage,
  output mul_pkg::mul_result_t  result
);

  // full product of the element at byte base, nb bytes wide,
  // valid in the low 16*nb bits
  function automatic logic [63:0] elem_prod(
    input logic [15:0][15:0] tile,
    input int                base,
    input int                nb,
    input logic              s2,
    input logic              s1
  );
    logic [63:0] acc;
    logic [15:0] p;
    logic        ext;
    int          i;
    int          j;
    acc = '0;
    for (i = 0; i < 4; i++) begin  // src2 byte
      for (j = 0; j < 4; j++) begin  // src1 byte
        if (i < nb && j < nb) begin
          p   = tile[(base + j)*4 + base + i];
          ext = ((i == nb-1 && s2) || (j == nb-1 && s1)) && p[15];
          acc = acc + ({{48{ext}}, p} << (8*(i + j)));
        end
      end
    end
    return acc;
  endfunction

  // {sat, data} for one element of width w
  function automatic logic [32:0] elem_out(
    input logic [63:0]         full,
    input int                  w,
    input logic                keep_low,
    input logic                is_smul,
    input mul_pkg::mul_vxrm_e  vxrm
  );
    logic [63:0] mask;
    logic [63:0] half;
    logic [63:0] rnd;
    logic        rbit;
    logic        lower;
    logic        lsb;
    logic        incr;
    logic        sat;
    mask  = (64'd1 << w) - 64'd1;
    rbit  = full[w-2];  // first bit below the cut
    lower = |(full & ((64'd1 << (w-2)) - 64'd1));
    lsb   = full[w-1];
    case (vxrm)
      mul_pkg::RNU: incr = rbit;
      mul_pkg::RNE: incr = rbit & (lower | lsb);
      mul_pkg::RDN: incr = 1'b0;
      default:      incr = !lsb & (rbit | lower);  // ROD
    endcase
    sat = !full[2*w-1] && full[2*w-2];  // only -min * -min
    if (!is_smul) begin
      half = keep_low ? (full & mask) : ((full >> w) & mask);
      return {1'b0, half[31:0]};
    end
    rnd = sat ? (mask >> 1) : (((full >> (w-1)) + {63'd0, incr}) & mask);
    return {sat, rnd[31:0]};
  endfunction

  logic [`MUL_VLEN-1:0]   data8;
  logic [`MUL_VLEN-1:0]   data16;
  logic [`MUL_VLEN-1:0]   data32;
  logic [`MUL_VLENB-1:0]  sat8;
  logic [`MUL_VLENB-1:0]  sat16;
  logic [`MUL_VLENB-1:0]  sat32;

  always_comb begin : combine
    logic [15:0][15:0] tile;
    logic [32:0]       r;
    int                z;
    int                e;
    sat16 = '0;  // vxsat sits on the top byte only
    sat32 = '0;
    for (z = 0; z < 4; z++) begin
      tile = stage.pp[z*16 +: 16];
      for (e = 0; e < 4; e++) begin
        r = elem_out(elem_prod(tile, e, 1, stage.ctrl.src2_signed, stage.ctrl.src1_signed),
                     8, stage.ctrl.keep_low, stage.ctrl.is_smul, stage.ctrl.vxrm);
        data8[(z*4 + e)*8 +: 8] = r[7:0];
        sat8[z*4 + e]           = r[32];
      end
      for (e = 0; e < 2; e++) begin
        r = elem_out(elem_prod(tile, 2*e, 2, stage.ctrl.src2_signed, stage.ctrl.src1_signed),
                     16, stage.ctrl.keep_low, stage.ctrl.is_smul, stage.ctrl.vxrm);
        data16[(z*2 + e)*16 +: 16] = r[15:0];
        sat16[z*4 + e*2 + 1]       = r[32];
      end
      r = elem_out(elem_prod(tile, 0, 4, stage.ctrl.src2_signed, stage.ctrl.src1_signed),
                   32, stage.ctrl.keep_low, stage.ctrl.is_smul, stage.ctrl.vxrm);
      data32[z*32 +: 32] = r[31:0];
      sat32[z*4 + 3]     = r[32];
    end
  end

  always_comb begin
    result.tag = stage.ctrl.tag;
    case (stage.ctrl.eew)
      mul_pkg::EEW16: begin
        result.data  = data16;
        result.vxsat = sat16;
      end
      mul_pkg::EEW32: begin
        result.data  = data32;
        result.vxsat = sat32;
      end
      default: begin  // eew8
        result.data  = data8;
        result.vxsat = sat8;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mul_result_queue.sv
////////////////////////////////////////////////////////////
// result queue
// holds finished results until the rob grants a credit,
// returns one input credit per result sent
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_result_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_valid,
  input  mul_pkg::mul_result_t  wr_data,
  input  logic                  out_credit,
  output logic                  out_valid,
  output mul_pkg::mul_result_t  out,
  output logic                  in_credit
);

  localparam int PTR_W = $clog2(`MUL_BUF_DEPTH);

  mul_pkg::mul_result_t       mem [`MUL_BUF_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [PTR_W:0]             entry_cnt;
  logic [`MUL_CREDIT_W-1:0]   credit_cnt;  // rob keeps at most 7 outstanding
  logic                       empty;
  logic                       pop;

  assign empty     = (entry_cnt == '0);
  assign pop       = !empty && (credit_cnt != '0);
  assign out_valid = pop;
  assign in_credit = pop;  // slot freed, station may issue again
  assign out       = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      entry_cnt  <= '0;
      credit_cnt <= '0;
    end else begin
      if (wr_valid) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_valid, pop})
        2'b10:   entry_cnt <= entry_cnt + 1'b1;
        2'b01:   entry_cnt <= entry_cnt - 1'b1;
        default: ;
      endcase
      case ({out_credit, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid) mem[wr_ptr] <= wr_data;
  end

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
////////////////////////////////////////////////////////////
// vector multiply unit, top level
// decoder and byte array, lane combiner, result queue
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  uop_valid,
  input  mul_pkg::mul_uop_t     uop,
  input  logic                  out_credit,
  output logic                  in_credit,
  output logic                  out_valid,
  output mul_pkg::mul_result_t  out
);

  logic [`MUL_VLEN-1:0]   src2;
  logic [`MUL_VLEN-1:0]   src1;
  logic [`MUL_VLENB-1:0]  src2_signed_b;
  logic [`MUL_VLENB-1:0]  src1_signed_b;
  mul_pkg::mul_ctrl_t     ctrl;
  logic                   stage_valid;
  mul_pkg::mul_stage_t    stage;
  mul_pkg::mul_result_t   result;

  mul_uop_decode u_decode (
    .uop           (uop),
    .uop_valid     (uop_valid),
    .src2          (src2),
    .src1          (src1),
    .src2_signed_b (src2_signed_b),
    .src1_signed_b (src1_signed_b),
    .ctrl          (ctrl)
  );

  mul_byte_array u_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (uop_valid),
    .src2          (src2),
    .src1          (src1),
    .src2_signed_b (src2_signed_b),
    .src1_signed_b (src1_signed_b),
    .ctrl          (ctrl),
    .stage_valid   (stage_valid),
    .stage         (stage)
  );

  mul_lane_combine u_combine (
    .stage  (stage),
    .result (result)
  );

  mul_result_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (stage_valid),
    .wr_data    (result),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out        (out),
    .in_credit  (in_credit)
  );

endmodule

`default_nettype wire

// File: sim/mul_unit_sva.sv
////////////////////////////////////////////////////////////
// result queue assertions
// overflow, credit use and credit return pulses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_unit_sva #(
  parameter int CNT_W = $clog2(`MUL_BUF_DEPTH) + 1
) (
  input logic             clk,
  input logic             rst_n,
  input logic             wr_valid,
  input logic             out_credit,
  input logic             out_valid,
  input logic             in_credit,
  input logic [CNT_W-1:0] entry_cnt
);

  logic [`MUL_CREDIT_W:0] grant_bal;  // grants not yet used by a result

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_bal <= '0;
    end else begin
      case ({out_credit, out_valid})
        2'b10:   grant_bal <= grant_bal + 1'b1;
        2'b01:   grant_bal <= grant_bal - 1'b1;
        default: ;
      endcase
    end
  end

  no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid |-> int'(entry_cnt) < `MUL_BUF_DEPTH)
    else $error("result queue written while full");

  credit_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> grant_bal != '0)
    else $error("out_valid with zero output credits");

  // a slot frees exactly when a held result meets a granted credit
  pulse_pair: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit == (entry_cnt != '0 && grant_bal != '0))
    else $error("in_credit does not match a result sent");

endmodule

`default_nettype wire

// File: sim/mul_tb_clock.sv
////////////////////////////////////////////////////////////
// testbench clock, 40 ns period
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // half period
  end

endmodule

`default_nettype wire

// File: sim/mul_tb.sv
////////////////////////////////////////////////////////////
// vector multiply unit testbench
// random micro-ops against a reference model, emulated
// station and rob credits, in-order result checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mul_defs.svh"

module mul_tb;

  localparam int N_PLAIN = 40;
  localparam int N_SMUL  = 40;
  localparam int N_BP    = 30;
  localparam int N_CRED  = 30;
  localparam int N_UOPS  = 2 + N_PLAIN + N_SMUL + N_BP + N_CRED;
  localparam int ROB_MAX = 6;  // keeps the 3-bit credit counter in range

  logic                  clk;
  logic                  rst_n;
  logic                  uop_valid;
  logic                  out_credit;
  logic                  in_credit;
  logic                  out_valid;
  mul_pkg::mul_uop_t     uop;
  mul_pkg::mul_result_t  out;
  mul_pkg::mul_result_t  exp_q [$];  // expected results, issue order
  int                    issued_cnt    = 0;
  int                    returned_cnt  = 0;  // in_credit pulses
  int                    delivered_cnt = 0;
  int                    granted_cnt   = 0;  // out_credit pulses
  int                    max_inflight  = 0;
  int                    err_cnt       = 0;
  int                    check_cnt     = 0;
  int                    rob_mode      = 0;  // 0 none, 1 plenty, 2 bursts
  logic [31:0]           stim_rng      = 32'd82;
  logic [31:0]           rob_rng       = 32'd82;

  mul_tb_clock u_clock (.clk(clk));

  mul_unit u_mul_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out        (out)
  );

  bind mul_result_queue mul_unit_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (wr_valid),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .in_credit  (in_credit),
    .entry_cnt  (entry_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic int elem_width(input mul_pkg::mul_eew_e eew);
    case (eew)
      mul_pkg::EEW16: return 16;
      mul_pkg::EEW32: return 32;
      default:        return 8;  // code 3 too
    endcase
  endfunction

  function automatic int station_credits();
    return `MUL_BUF_DEPTH - issued_cnt + returned_cnt;
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model, element by element
  ////////////////////////////////////////////////////////////
  function automatic mul_pkg::mul_result_t model_result(input mul_pkg::mul_uop_t u);
    mul_pkg::mul_result_t res;
    logic [127:0] src1;
    logic [31:0]  mask;
    logic [31:0]  minv;
    logic [31:0]  a_raw;
    logic [31:0]  b_raw;
    logic [31:0]  r;
    logic [65:0]  a;
    logic [65:0]  b;
    logic [65:0]  p;
    logic [65:0]  sticky;
    logic         a_sgn;
    logic         b_sgn;
    logic         high;
    logic         smul;
    logic         inc;
    int           w;
    int           e;
    w     = elem_width(u.eew);
    mask  = 32'hffff_ffff >> (32 - w);
    minv  = 32'd1 << (w - 1);
    a_sgn = 1'b1;
    b_sgn = 1'b1;
    high  = 1'b0;
    smul  = 1'b0;
    case (u.op)
      mul_pkg::MULH: high = 1'b1;
      mul_pkg::MULHU: begin
        a_sgn = 1'b0;
        b_sgn = 1'b0;
        high  = 1'b1;
      end
      mul_pkg::MULHSU: begin
        b_sgn = 1'b0;  // vs1 or rs1 unsigned
        high  = 1'b1;
      end
      mul_pkg::SMUL: smul = 1'b1;
      default: ;  // plain low product
    endcase
    src1 = u.vs1;
    if (u.is_vx) begin
      src1 = '0;
      for (e = 0; e < 128 / w; e++) src1 = src1 | (128'(u.rs1 & mask) << (e * w));
    end
    res     = '0;
    res.tag = u.tag;
    for (e = 0; e < 128 / w; e++) begin
      a_raw = 32'(u.vs2 >> (e * w)) & mask;
      b_raw = 32'(src1 >> (e * w)) & mask;
      a     = {34'd0, a_raw};
      b     = {34'd0, b_raw};
      if (a_sgn && a_raw[w-1]) a = a | ~{34'd0, mask};
      if (b_sgn && b_raw[w-1]) b = b | ~{34'd0, mask};
      p = a * b;
      if (!smul) begin
        r = 32'(high ? (p >> w) : p) & mask;
      end else if (a_raw == minv && b_raw == minv) begin
        r = minv - 32'd1;  // clamp to largest positive
        res.vxsat[(e + 1) * w / 8 - 1] = 1'b1;
      end else begin
        sticky = p & ((66'd1 << (w - 2)) - 66'd1);
        case (u.vxrm)
          mul_pkg::RNU: inc = p[w-2];
          mul_pkg::RNE: inc = p[w-2] & ((|sticky) | p[w-1]);
          mul_pkg::RDN: inc = 1'b0;
          default:      inc = !p[w-1] & (p[w-2] | (|sticky));
        endcase
        r = (32'(p >> (w - 1)) + 32'(inc)) & mask;
      end
      res.data = res.data | (128'(r) << (e * w));
    end
    return res;
  endfunction

  // kind 0 plain multiply, 1 vsmul, 2 either
  task automatic make_uop(input int kind, output mul_pkg::mul_uop_t u);
    logic [31:0]  rv;
    logic [127:0] minv;
    logic [127:0] mask;
    int           w;
    int           e;
    int           i;
    int           k;
    u = '0;
    for (i = 0; i < 4; i++) begin
      u.vs2[i*32 +: 32] = next_rand();
      u.vs1[i*32 +: 32] = next_rand();
    end
    u.rs1   = next_rand();
    u.tag   = 4'(issued_cnt);
    rv      = next_rand();
    u.is_vx = rv[0];
    u.eew   = mul_pkg::mul_eew_e'(rv[2:1]);
    u.vxrm  = mul_pkg::mul_vxrm_e'(rv[4:3]);
    k       = (kind == 2) ? int'(rv[8]) : kind;
    if (k == 0) begin
      if (rv[7:5] == 3'd4) u.op = mul_pkg::MULHSU;
      else u.op = mul_pkg::mul_op_e'(rv[7:5]);  // 5..7 act as vmul
    end else begin
      u.op = mul_pkg::SMUL;
      w    = elem_width(u.eew);
      minv = 128'd1 << (w - 1);
      mask = (128'd1 << w) - 128'd1;
      for (e = 0; e < 128 / w; e++) begin
        rv = next_rand();
        if (rv[1:0] == 2'd0) begin  // both most negative
          u.vs2 = (u.vs2 & ~(mask << (e * w))) | (minv << (e * w));
          u.vs1 = (u.vs1 & ~(mask << (e * w))) | (minv << (e * w));
        end else if (rv[1:0] == 2'd1) begin
          u.vs2 = (u.vs2 & ~(mask << (e * w))) | (minv << (e * w));
        end
      end
      if (rv[2]) u.rs1 = minv[31:0];
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] exp_v,
                             input logic [127:0] got_v);
    check_cnt++;
    assert (got_v === exp_v) else begin
      $display("FAILED %0d ns %s expected %h got %h", $time, name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // station side
  ////////////////////////////////////////////////////////////
  task automatic issue_uops(input int kind, input int n);
    mul_pkg::mul_uop_t u;
    int                sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      #2;
      if (station_credits() > 0) begin
        make_uop(kind, u);
        uop       = u;
        uop_valid = 1'b1;
        exp_q.push_back(model_result(u));
        issued_cnt++;
        sent++;
        if (issued_cnt - returned_cnt > max_inflight) max_inflight = issued_cnt - returned_cnt;
      end else begin
        uop_valid = 1'b0;  // out of credits
      end
    end
    @(posedge clk);
    #2;
    uop_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int n, input int e0);
    $display("test %s: %0d uops, %0d errors", name, n, err_cnt - e0);
  endtask

  task automatic run_phase(input string name, input int kind, input int n, input int mode);
    int e0;
    e0       = err_cnt;
    rob_mode = mode;
    issue_uops(kind, n);
    drain();
    report_test(name, n, e0);
  endtask

  // reorder buffer credit grants
  initial begin : rob_credits
    int burst;
    int gap;
    burst = 0;
    gap   = 0;
    forever begin
      @(posedge clk);
      #2;
      out_credit = 1'b0;
      if (rob_mode == 1 && granted_cnt - delivered_cnt < ROB_MAX) begin
        out_credit = 1'b1;
      end else if (rob_mode == 2) begin
        if (burst > 0) begin
          if (granted_cnt - delivered_cnt < ROB_MAX) out_credit = 1'b1;
          burst--;
        end else if (gap > 0) begin
          gap--;
        end else begin
          rob_rng = xorshift32(rob_rng);
          burst   = 1 + int'(rob_rng[1:0]);
          gap     = 6 + int'(rob_rng[6:2]);  // long quiet stretch
        end
      end
    end
  end

  // sample everything mid-cycle
  always @(negedge clk) begin : monitor
    mul_pkg::mul_result_t exp_res;
    if (!rst_n) begin
      assert (!out_valid && !in_credit) else begin
        $display("out_valid or in_credit high during reset at %0d ns", $time);
        err_cnt++;
      end
    end else begin
      if (in_credit) returned_cnt++;
      if (out_valid) begin
        assert (delivered_cnt < granted_cnt) else begin
          $display("result sent without an output credit at %0d ns", $time);
          err_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("result sent with no micro-op outstanding at %0d ns", $time);
          err_cnt++;
        end else begin
          exp_res = exp_q.pop_front();
          check_value("out.tag", 128'(exp_res.tag), 128'(out.tag));
          check_value("out.data", exp_res.data, out.data);
          check_value("out.vxsat", 128'(exp_res.vxsat), 128'(out.vxsat));
        end
        delivered_cnt++;
      end
      if (out_credit) granted_cnt++;
    end
  end

  initial begin : watchdog
    #(N_UOPS * 60 * 40);
    $display("timeout: results still missing after %0d ns", N_UOPS * 60 * 40);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    int e0;
    rst_n      = 1'b0;
    uop_valid  = 1'b0;
    uop        = '0;
    out_credit = 1'b0;

    // reset, then two results held back until credits arrive
    e0 = err_cnt;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    issue_uops(0, 2);
    repeat (12) begin
      @(negedge clk);
      assert (!out_valid && !in_credit) else begin
        $display("result sent before any output credit at %0d ns", $time);
        err_cnt++;
      end
    end
    rob_mode = 1;
    drain();
    report_test("reset", 2, e0);

    run_phase("plain_mul", 0, N_PLAIN, 1);
    run_phase("vsmul", 1, N_SMUL, 1);
    run_phase("backpressure", 2, N_BP, 2);

    e0           = err_cnt;
    rob_mode     = 1;
    max_inflight = 0;
    issue_uops(2, N_CRED);
    drain();
    check_value("in_credit pulses", 128'(issued_cnt), 128'(returned_cnt));
    check_value("results delivered", 128'(issued_cnt), 128'(delivered_cnt));
    check_value("station credits", 128'(`MUL_BUF_DEPTH), 128'(station_credits()));
    assert (max_inflight >= 2) else begin
      $display("never more than one micro-op in flight");
      err_cnt++;
    end
    report_test("input_credits", N_CRED, e0);

    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/mul_pkg.sv
hw/mul_uop_decode.sv
hw/mul_byte_array.sv
hw/mul_lane_combine.sv
hw/mul_result_queue.sv
hw/mul_unit.sv
sim/mul_unit_sva.sv
sim/mul_tb_clock.sv
sim/mul_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the multiply unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mul_tb -f list.f -o mul_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/mul_tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^No errors$"; then
  exit 0
fi
exit 1
